/* bench/ddr_xfer_stim.txt */
// slots 0 to 7: segment head, burst count (hex words)
// then read head and read burst count, then expected AW bursts, W beats, read beats
00001000 00000003
00004000 00000002
00000800 00000001
00000000 00000000
00000000 00000000
00000000 00000000
00000000 00000000
00000000 00000000
00001000 00000003
00000006 00000018 0000000c

/* bench/ddr_xfer_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_xfer_sva (
	input wire                          ddr_user_clk,
	input wire                          ddr_user_sync_rst,
	input wire ddr_xfer_pkg::ddr_addr_t ddr4_axi_awaddr,
	input wire                          ddr4_axi_awvalid,
	input wire                          ddr4_axi_awready,
	input wire ddr_xfer_pkg::ddr_data_t ddr4_axi_wdata,
	input wire                          ddr4_axi_wlast,
	input wire                          ddr4_axi_wvalid,
	input wire                          ddr4_axi_wready,
	input wire ddr_xfer_pkg::ddr_addr_t ddr4_axi_araddr,
	input wire                          ddr4_axi_arvalid,
	input wire                          ddr4_axi_arready,
	input wire                          mac_to_ddr_fifo_rd_en,
	input wire                          mac_to_ddr_done
);

	int fail_count = 0;  // assertion failures so far

	// a raised valid holds with its payload until taken
	aw_hold: assert property (@(posedge ddr_user_clk) disable iff (ddr_user_sync_rst)
		ddr4_axi_awvalid && !ddr4_axi_awready |=> ddr4_axi_awvalid && $stable(ddr4_axi_awaddr))
		else begin
			$error("AW request dropped or changed before acceptance");
			fail_count++;
		end

	w_hold: assert property (@(posedge ddr_user_clk) disable iff (ddr_user_sync_rst)
		ddr4_axi_wvalid && !ddr4_axi_wready |=>
		ddr4_axi_wvalid && $stable(ddr4_axi_wdata) && $stable(ddr4_axi_wlast))
		else begin
			$error("W beat dropped or changed before acceptance");
			fail_count++;
		end

	ar_hold: assert property (@(posedge ddr_user_clk) disable iff (ddr_user_sync_rst)
		ddr4_axi_arvalid && !ddr4_axi_arready |=> ddr4_axi_arvalid && $stable(ddr4_axi_araddr))
		else begin
			$error("AR request dropped or changed before acceptance");
			fail_count++;
		end

	// control outputs come out of reset low
	reset_low: assert property (@(posedge ddr_user_clk)
		ddr_user_sync_rst |=> !ddr4_axi_awvalid && !ddr4_axi_wvalid && !ddr4_axi_arvalid &&
		!mac_to_ddr_fifo_rd_en && !mac_to_ddr_done)
		else begin
			$error("control output high right after reset");
			fail_count++;
		end

	// done one cycle after the closing wlast transfer
	done_after_wlast: assert property (@(posedge ddr_user_clk) disable iff (ddr_user_sync_rst)
		mac_to_ddr_done |-> $past(ddr4_axi_wvalid && ddr4_axi_wready && ddr4_axi_wlast))
		else begin
			$error("done without a wlast transfer the cycle before");
			fail_count++;
		end

endmodule

`default_nettype wire

/* bench/ddr_xfer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_xfer_tb;
	import ddr_xfer_pkg::*;

	logic                       ddr_user_clk;
	logic                       ddr_user_sync_rst;
	logic                       cfg_valid;
	wr_cfg_t                    cfg_value_wr_ddr;
	seg_t                       cfg_value_rd_ddr;
	logic                       init_calib_complete;
	logic                       ddr_to_mac_start;
	ddr_data_t                  mac_to_ddr_fifo_dout;
	logic                       mac_to_ddr_fifo_empty;
	logic                       mac_to_ddr_fifo_rd_en;
	logic                       mac_to_ddr_done;
	ddr_data_t                  ddr_to_mac_data;
	logic                       ddr_to_mac_data_valid;
	ddr_addr_t                  ddr4_axi_awaddr;
	logic [7:0]                 ddr4_axi_awlen;
	logic                       ddr4_axi_awvalid;
	logic                       ddr4_axi_awready;
	ddr_data_t                  ddr4_axi_wdata;
	logic [DATA_W/8-1:0]        ddr4_axi_wstrb;
	logic                       ddr4_axi_wlast;
	logic                       ddr4_axi_wvalid;
	logic                       ddr4_axi_wready;
	logic                       ddr4_axi_bvalid;
	logic                       ddr4_axi_bready;
	ddr_addr_t                  ddr4_axi_araddr;
	logic [7:0]                 ddr4_axi_arlen;
	logic                       ddr4_axi_arvalid;
	logic                       ddr4_axi_arready;
	ddr_data_t                  ddr4_axi_rdata;
	logic                       ddr4_axi_rvalid;
	logic                       ddr4_axi_rlast;
	logic                       ddr4_axi_rready;

	logic [31:0] stim [0:20];   // 8 slots, read word, 3 totals
	wr_cfg_t     wr_list;
	ddr_addr_t   exp_aw [$];
	ddr_addr_t   exp_ar [$];
	ddr_addr_t   aw_q [$];      // accepted AW waiting for W data
	ddr_addr_t   ar_q [$];      // accepted AR waiting for R beats
	ddr_data_t   fifo_q [$];    // FIFO words consumed, not yet on W
	ddr_data_t   mem [0:4095];
	ddr_data_t   ref_mem [0:4095];
	logic [31:0] lfsr = 32'hff20_0c55;
	burst_cnt_t  aw_n = '0;
	burst_cnt_t  w_n = '0;
	burst_cnt_t  ar_n = '0;
	burst_cnt_t  r_n = '0;
	burst_cnt_t  done_n = '0;
	int          cycles = 0;
	int          limit = 0;
	int          r_beat = 0;
	int          b_pending = 0;
	logic        need_word = 1'b1;
	logic        r_taken = 1'b0;
	logic        r_real = 1'b0;   // current R beat answers an AR
	logic        cfg_sent = 1'b0;
	logic        rd_sent = 1'b0;

	ddr_xfer_top #(
		.BUF_DEPTH (16)
	) i_ddr_xfer_top (.*);

	bind ddr_xfer_top ddr_xfer_sva i_ddr_xfer_sva (
		.ddr_user_clk          (ddr_user_clk),
		.ddr_user_sync_rst     (ddr_user_sync_rst),
		.ddr4_axi_awaddr       (ddr4_axi_awaddr),
		.ddr4_axi_awvalid      (ddr4_axi_awvalid),
		.ddr4_axi_awready      (ddr4_axi_awready),
		.ddr4_axi_wdata        (ddr4_axi_wdata),
		.ddr4_axi_wlast        (ddr4_axi_wlast),
		.ddr4_axi_wvalid       (ddr4_axi_wvalid),
		.ddr4_axi_wready       (ddr4_axi_wready),
		.ddr4_axi_araddr       (ddr4_axi_araddr),
		.ddr4_axi_arvalid      (ddr4_axi_arvalid),
		.ddr4_axi_arready      (ddr4_axi_arready),
		.mac_to_ddr_fifo_rd_en (mac_to_ddr_fifo_rd_en),
		.mac_to_ddr_done       (mac_to_ddr_done)
	);

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [127:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[126:0], lfsr[0]};
		end
	endtask

	function automatic int word_idx(input ddr_addr_t a);
		return int'(a[15:4]);  // 16-byte beats
	endfunction

	task automatic stop_run();
		$display("Regression failed");
		$fatal(1, "first error, run stopped");
	endtask

	task automatic report_failure(input string why);
		$display("%s", why);
		stop_run();
	endtask

	task automatic check_assertions();
		if (i_ddr_xfer_top.i_ddr_xfer_sva.fail_count != 0)
			report_failure("a protocol assertion on the DUT ports failed");
	endtask

	task automatic check_addr(input string name, input ddr_addr_t got, input ddr_addr_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_data(input string name, input ddr_data_t got, input ddr_data_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_count(input string name, input burst_cnt_t got, input burst_cnt_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	// expected AW and AR address lists, run length limit
	task automatic load_expected();
		int last;
		last = -1;
		for (int i = 0; i < SEG_COUNT; i++) begin
			wr_list[i].head = stim[2*i];
			wr_list[i].num  = stim[2*i+1];
			if (stim[2*i] != 0 || stim[2*i+1] != 0)
				last = i;  // list ends after the last nonzero slot
		end
		for (int i = 0; i <= last; i++)
			for (int k = 0; k < wr_list[i].num; k++)
				exp_aw.push_back(wr_list[i].head[DDR_ADDR_W-1:0] + DDR_ADDR_W'(BURST_BYTES * k));
		for (int k = 0; k < stim[17]; k++)
			exp_ar.push_back(stim[16][DDR_ADDR_W-1:0] + DDR_ADDR_W'(BURST_BYTES * k));
		limit = 20 * (stim[19] + stim[20]) + 200;
	endtask

	initial begin
		ddr_user_clk = 1'b0;
		forever #20 ddr_user_clk = ~ddr_user_clk;
	end

	always @(posedge ddr_user_clk) begin
		cycles++;
		check_assertions();
		if (cycles > limit)
			report_failure($sformatf("timeout after %0d cycles, transfers unfinished", cycles));
	end

	// FIFO and DDR slave models, all random draws in one process
	always @(negedge ddr_user_clk) begin
		logic [127:0] r;
		if (need_word) begin
			rand_bits(DATA_W, r);
			mac_to_ddr_fifo_dout = r;
			need_word = 1'b0;
		end
		rand_bits(2, r);
		mac_to_ddr_fifo_empty = (r[1:0] == 2'b00);  // gap one time in four
		rand_bits(2, r);
		ddr4_axi_awready = (r[1:0] != 2'b00);
		rand_bits(2, r);
		ddr4_axi_wready = (aw_q.size() > 0) && (r[1:0] != 2'b00);  // W waits for its AW
		rand_bits(2, r);
		ddr4_axi_arready = (r[1:0] != 2'b00);
		ddr4_axi_bvalid = (b_pending > 0);
		if (!ddr4_axi_rvalid || r_taken) begin
			rand_bits(2, r);
			r_real = (ar_q.size() > 0);
			if (r_real) begin
				ddr4_axi_rvalid = (r[1:0] != 2'b00);
				ddr4_axi_rdata  = mem[word_idx(ar_q[0]) + r_beat];
				ddr4_axi_rlast  = (r_beat == BURST_LEN);
			end else begin
				// stray beats outside the read window, the MAC gate has to hide them
				ddr4_axi_rvalid = (!rd_sent || r_n == stim[20]) && (r[1:0] == 2'b11);
				ddr4_axi_rlast  = r[0];
			end
		end
	end

	always @(posedge ddr_user_clk) begin
		ddr_data_t exp_word;
		int        beat;
		if (!ddr_user_sync_rst) begin
			if (!cfg_sent)
				check_count("{awvalid,wvalid,fifo_rd_en,done}", burst_cnt_t'({ddr4_axi_awvalid,
					ddr4_axi_wvalid, mac_to_ddr_fifo_rd_en, mac_to_ddr_done}), '0);
			if (!rd_sent)
				check_count("{arvalid,data_valid}",
					burst_cnt_t'({ddr4_axi_arvalid, ddr_to_mac_data_valid}), '0);
			if (ddr_to_mac_start)
				rd_sent = 1'b1;
			if (!init_calib_complete)
				check_count("{bready,rready}", burst_cnt_t'({ddr4_axi_bready, ddr4_axi_rready}), '0);
			if (mac_to_ddr_fifo_rd_en) begin
				if (mac_to_ddr_fifo_empty)
					report_failure("FIFO read enable high while the FIFO is empty");
				fifo_q.push_back(mac_to_ddr_fifo_dout);
				need_word = 1'b1;
			end
			if (ddr4_axi_awvalid && ddr4_axi_awready) begin
				if (aw_n >= exp_aw.size())
					report_failure("more AW bursts than the segment list holds");
				check_addr("ddr4_axi_awaddr", ddr4_axi_awaddr, exp_aw[aw_n]);
				check_count("ddr4_axi_awlen", burst_cnt_t'(ddr4_axi_awlen), burst_cnt_t'(BURST_LEN));
				aw_q.push_back(ddr4_axi_awaddr);
				aw_n++;
			end
			if (ddr4_axi_wvalid && ddr4_axi_wready) begin
				if (fifo_q.size() == 0 || w_n >= stim[19])
					report_failure("W beat with no FIFO word or list entry behind it");
				exp_word = fifo_q.pop_front();
				beat = w_n % BURST_BEATS;
				check_data("ddr4_axi_wdata", ddr4_axi_wdata, exp_word);
				check_count("ddr4_axi_wlast", burst_cnt_t'(ddr4_axi_wlast),
					burst_cnt_t'(beat == BURST_LEN));
				check_count("ddr4_axi_wstrb", burst_cnt_t'(ddr4_axi_wstrb), 32'h0000_ffff);
				mem[word_idx(aw_q[0]) + beat] = ddr4_axi_wdata;
				ref_mem[word_idx(exp_aw[w_n / BURST_BEATS]) + beat] = exp_word;
				if (ddr4_axi_wlast) begin
					void'(aw_q.pop_front());
					b_pending++;
				end
				w_n++;
			end
			if (ddr4_axi_bvalid && ddr4_axi_bready)
				b_pending--;
			if (mac_to_ddr_done) begin
				if (w_n != stim[19])
					report_failure("done pulsed before the final W transfer");
				if (done_n != 0)
					report_failure("done pulsed more than once");
				done_n++;
			end
			if (ddr4_axi_arvalid && ddr4_axi_arready) begin
				if (ar_n >= stim[17])
					report_failure("more AR bursts than the read count");
				check_addr("ddr4_axi_araddr", ddr4_axi_araddr, exp_ar[ar_n]);
				check_count("ddr4_axi_arlen", burst_cnt_t'(ddr4_axi_arlen), burst_cnt_t'(BURST_LEN));
				ar_q.push_back(ddr4_axi_araddr);
				ar_n++;
			end
			r_taken = ddr4_axi_rvalid && ddr4_axi_rready;
			if (r_taken && r_real) begin
				if (r_beat == BURST_LEN) begin
					r_beat = 0;
					void'(ar_q.pop_front());
				end else begin
					r_beat++;
				end
			end
			if (ddr_to_mac_data_valid) begin
				if (r_n >= stim[20])
					report_failure("data valid to the MAC after the last read burst");
				beat = r_n % BURST_BEATS;
				check_data("ddr_to_mac_data", ddr_to_mac_data,
					ref_mem[word_idx(exp_ar[r_n / BURST_BEATS]) + beat]);
				r_n++;
			end
		end
	end

	initial begin
		ddr_user_sync_rst     = 1'b1;
		cfg_valid             = 1'b0;
		cfg_value_wr_ddr      = '0;
		cfg_value_rd_ddr      = '0;
		init_calib_complete   = 1'b0;
		ddr_to_mac_start      = 1'b0;
		mac_to_ddr_fifo_dout  = '0;
		mac_to_ddr_fifo_empty = 1'b1;
		ddr4_axi_awready      = 1'b0;
		ddr4_axi_wready       = 1'b0;
		ddr4_axi_bvalid       = 1'b0;
		ddr4_axi_arready      = 1'b0;
		ddr4_axi_rdata        = '0;
		ddr4_axi_rvalid       = 1'b0;
		ddr4_axi_rlast        = 1'b0;
		$readmemh("bench/ddr_xfer_stim.txt", stim);
		load_expected();
		repeat (5) @(negedge ddr_user_clk);
		ddr_user_sync_rst = 1'b0;
		repeat (3) @(negedge ddr_user_clk);
		init_calib_complete = 1'b1;
		repeat (2) @(negedge ddr_user_clk);
		cfg_value_wr_ddr = wr_list;
		cfg_valid        = 1'b1;
		cfg_sent         = 1'b1;
		@(negedge ddr_user_clk);
		cfg_valid = 1'b0;
		wait (done_n == 1);
		check_count("AW bursts", aw_n, stim[18]);
		check_count("W beats", w_n, stim[19]);
		@(negedge ddr_user_clk);
		cfg_value_rd_ddr = seg_t'({stim[17], stim[16]});  // count high, head low
		ddr_to_mac_start = 1'b1;
		@(negedge ddr_user_clk);
		ddr_to_mac_start = 1'b0;
		wait (r_n == stim[20]);
		repeat (20) @(negedge ddr_user_clk);  // room for a stray beat to show
		check_count("AR bursts", ar_n, stim[17]);
		check_count("ddr4_axi_arvalid", burst_cnt_t'(ddr4_axi_arvalid), '0);
		check_count("read beats", r_n, stim[20]);
		check_count("done pulses", done_n, 32'd1);
		check_count("write responses outstanding", burst_cnt_t'(b_pending), '0);
		check_assertions();
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

/* design/ddr_xfer_pkg.sv */
`default_nettype none

package ddr_xfer_pkg;

	localparam int DDR_ADDR_W  = 29;
	localparam int DATA_W      = 128;
	localparam int BURST_BEATS = 4;
	localparam int BURST_LEN   = BURST_BEATS - 1;  // axi len code
	localparam int BURST_BYTES = 64;               // 4 beats of 16 bytes
	localparam int SEG_COUNT   = 8;

	typedef logic [DDR_ADDR_W-1:0] ddr_addr_t;
	typedef logic [DATA_W-1:0]     ddr_data_t;
	typedef logic [31:0]           burst_cnt_t;

	// one list slot, head in the upper half
	typedef struct packed {
		logic [31:0] head;
		burst_cnt_t  num;
	} seg_t;

	// whole write list, slot 0 in the low bits
	typedef seg_t [SEG_COUNT-1:0] wr_cfg_t;

endpackage

`default_nettype wire

/* design/ddr_xfer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_xfer_top #(
	parameter int BUF_DEPTH = 16
) (
	input  wire                                     ddr_user_clk,
	input  wire                                     ddr_user_sync_rst,
	input  wire                                     cfg_valid,
	input  wire ddr_xfer_pkg::wr_cfg_t              cfg_value_wr_ddr,
	input  wire ddr_xfer_pkg::seg_t                 cfg_value_rd_ddr,
	input  wire                                     init_calib_complete,
	input  wire                                     ddr_to_mac_start,
	input  wire ddr_xfer_pkg::ddr_data_t            mac_to_ddr_fifo_dout,
	input  wire                                     mac_to_ddr_fifo_empty,
	output logic                                    mac_to_ddr_fifo_rd_en,
	output logic                                    mac_to_ddr_done,
	output ddr_xfer_pkg::ddr_data_t                 ddr_to_mac_data,
	output logic                                    ddr_to_mac_data_valid,
	output ddr_xfer_pkg::ddr_addr_t                 ddr4_axi_awaddr,
	output logic [7:0]                              ddr4_axi_awlen,
	output logic                                    ddr4_axi_awvalid,
	input  wire                                     ddr4_axi_awready,
	output ddr_xfer_pkg::ddr_data_t                 ddr4_axi_wdata,
	output logic [ddr_xfer_pkg::DATA_W/8-1:0]       ddr4_axi_wstrb,
	output logic                                    ddr4_axi_wlast,
	output logic                                    ddr4_axi_wvalid,
	input  wire                                     ddr4_axi_wready,
	input  wire                                     ddr4_axi_bvalid,
	output logic                                    ddr4_axi_bready,
	output ddr_xfer_pkg::ddr_addr_t                 ddr4_axi_araddr,
	output logic [7:0]                              ddr4_axi_arlen,
	output logic                                    ddr4_axi_arvalid,
	input  wire                                     ddr4_axi_arready,
	input  wire ddr_xfer_pkg::ddr_data_t            ddr4_axi_rdata,
	input  wire                                     ddr4_axi_rvalid,
	input  wire                                     ddr4_axi_rlast,
	output logic                                    ddr4_axi_rready
);
	import ddr_xfer_pkg::*;

	seg_if seg ();

	// fixed 4-beat bursts, all byte lanes written
	assign ddr4_axi_awlen = 8'(BURST_LEN);
	assign ddr4_axi_arlen = 8'(BURST_LEN);
	assign ddr4_axi_wstrb = '1;

	// write responses are taken as they come, bvalid only seen by the slave side
	always_ff @(posedge ddr_user_clk) begin
		if (ddr_user_sync_rst)
			ddr4_axi_bready <= 1'b0;
		else if (init_calib_complete)
			ddr4_axi_bready <= 1'b1;
	end

	wr_segment_list i_wr_segment_list (
		.ddr_user_clk        (ddr_user_clk),
		.ddr_user_sync_rst   (ddr_user_sync_rst),
		.cfg_valid           (cfg_valid),
		.cfg_value           (cfg_value_wr_ddr),
		.init_calib_complete (init_calib_complete),
		.fifo_empty          (mac_to_ddr_fifo_empty),
		.seg                 (seg)
	);

	wr_addr_gen i_wr_addr_gen (
		.ddr_user_clk      (ddr_user_clk),
		.ddr_user_sync_rst (ddr_user_sync_rst),
		.seg               (seg),
		.awaddr            (ddr4_axi_awaddr),
		.awvalid           (ddr4_axi_awvalid),
		.awready           (ddr4_axi_awready)
	);

	wr_data_path #(
		.BUF_DEPTH (BUF_DEPTH)
	) i_wr_data_path (
		.ddr_user_clk      (ddr_user_clk),
		.ddr_user_sync_rst (ddr_user_sync_rst),
		.seg               (seg),
		.fifo_rd_en        (mac_to_ddr_fifo_rd_en),
		.fifo_dout         (mac_to_ddr_fifo_dout),
		.fifo_empty        (mac_to_ddr_fifo_empty),
		.wdata             (ddr4_axi_wdata),
		.wvalid            (ddr4_axi_wvalid),
		.wlast             (ddr4_axi_wlast),
		.wready            (ddr4_axi_wready),
		.done              (mac_to_ddr_done)
	);

	rd_channel i_rd_channel (
		.ddr_user_clk        (ddr_user_clk),
		.ddr_user_sync_rst   (ddr_user_sync_rst),
		.init_calib_complete (init_calib_complete),
		.start               (ddr_to_mac_start),
		.cfg_value           (cfg_value_rd_ddr),
		.araddr              (ddr4_axi_araddr),
		.arvalid             (ddr4_axi_arvalid),
		.arready             (ddr4_axi_arready),
		.rdata               (ddr4_axi_rdata),
		.rvalid              (ddr4_axi_rvalid),
		.rlast               (ddr4_axi_rlast),
		.rready              (ddr4_axi_rready),
		.mac_data            (ddr_to_mac_data),
		.mac_data_valid      (ddr_to_mac_data_valid)
	);

endmodule

`default_nettype wire

/* design/rd_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module rd_channel (
	input  wire                          ddr_user_clk,
	input  wire                          ddr_user_sync_rst,
	input  wire                          init_calib_complete,
	input  wire                          start,
	input  wire ddr_xfer_pkg::seg_t      cfg_value,
	output ddr_xfer_pkg::ddr_addr_t      araddr,
	output logic                         arvalid,
	input  wire                          arready,
	input  wire ddr_xfer_pkg::ddr_data_t rdata,
	input  wire                          rvalid,
	input  wire                          rlast,
	output logic                         rready,
	output ddr_xfer_pkg::ddr_data_t      mac_data,
	output logic                         mac_data_valid
);
	import ddr_xfer_pkg::*;

	burst_cnt_t rd_num;     // bursts requested by the strobe
	burst_cnt_t ar_cnt;
	burst_cnt_t r_cnt;      // completed bursts
	logic       gate;       // forwarding window to the mac
	logic       ar_fire;
	logic       r_end;

	assign ar_fire = arvalid && arready;
	assign r_end   = gate && rvalid && rready && rlast;

	// read word is head low, count high
	always_ff @(posedge ddr_user_clk) begin
		if (ddr_user_sync_rst) begin
			rd_num  <= '0;
			arvalid <= 1'b0;
			ar_cnt  <= '0;
		end else if (start) begin
			rd_num  <= cfg_value[63:32];
			arvalid <= (cfg_value[63:32] != '0);
			ar_cnt  <= '0;
		end else if (ar_fire) begin
			if (ar_cnt == rd_num - 32'd1) begin
				arvalid <= 1'b0;
				ar_cnt  <= '0;
			end else begin
				ar_cnt <= ar_cnt + 32'd1;
			end
		end
	end

	always_ff @(posedge ddr_user_clk) begin
		if (start)
			araddr <= cfg_value[DDR_ADDR_W-1:0];
		else if (ar_fire)
			araddr <= araddr + DDR_ADDR_W'(BURST_BYTES);
	end

	always_ff @(posedge ddr_user_clk) begin
		if (ddr_user_sync_rst) begin
			gate  <= 1'b0;
			r_cnt <= '0;
		end else if (start) begin
			gate  <= (cfg_value[63:32] != '0);
			r_cnt <= '0;
		end else if (r_end) begin
			if (r_cnt == rd_num - 32'd1) begin
				gate  <= 1'b0;  // last burst back
				r_cnt <= '0;
			end else begin
				r_cnt <= r_cnt + 32'd1;
			end
		end
	end

	always_ff @(posedge ddr_user_clk) begin
		if (ddr_user_sync_rst)
			rready <= 1'b0;
		else
			rready <= init_calib_complete;
	end

	assign mac_data       = rdata;
	assign mac_data_valid = rvalid && gate;  // no back-pressure from the mac

endmodule

`default_nettype wire

/* design/seg_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface seg_if;
	import ddr_xfer_pkg::*;

	ddr_addr_t  head;       // address of first burst
	burst_cnt_t num;        // bursts in the segment
	logic       seg_start;
	logic       last_seg;   // nothing left in the list after this one
	logic       seg_done;   // final wlast of the segment accepted

	modport list (output head, num, seg_start, last_seg, input seg_done);
	modport addr (input head, num, seg_start);
	modport data (input num, seg_start, last_seg, output seg_done);

endinterface

`default_nettype wire

/* design/wr_addr_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module wr_addr_gen (
	input  wire                      ddr_user_clk,
	input  wire                      ddr_user_sync_rst,
	seg_if.addr                      seg,
	output ddr_xfer_pkg::ddr_addr_t  awaddr,
	output logic                     awvalid,
	input  wire                      awready
);
	import ddr_xfer_pkg::*;

	burst_cnt_t aw_cnt;   // aw transfers done in this segment
	logic       aw_fire;
	logic       aw_last;

	assign aw_fire = awvalid && awready;
	assign aw_last = (aw_cnt == seg.num - 32'd1);

	always_ff @(posedge ddr_user_clk) begin
		if (ddr_user_sync_rst) begin
			awvalid <= 1'b0;
			aw_cnt  <= '0;
		end else if (seg.seg_start) begin
			awvalid <= (seg.num != '0);
			aw_cnt  <= '0;
		end else if (aw_fire) begin
			if (aw_last) begin
				awvalid <= 1'b0;  // segment fully requested
				aw_cnt  <= '0;
			end else begin
				aw_cnt <= aw_cnt + 32'd1;
			end
		end
	end

	// address held stable until accepted
	always_ff @(posedge ddr_user_clk) begin
		if (seg.seg_start)
			awaddr <= seg.head;
		else if (aw_fire)
			awaddr <= awaddr + DDR_ADDR_W'(BURST_BYTES);
	end

endmodule

`default_nettype wire

/* design/wr_data_path.sv */
`timescale 1ns/1ps
`default_nettype none

module wr_data_path #(
	parameter int BUF_DEPTH = 16
) (
	input  wire                          ddr_user_clk,
	input  wire                          ddr_user_sync_rst,
	seg_if.data                          seg,
	output logic                         fifo_rd_en,
	input  wire ddr_xfer_pkg::ddr_data_t fifo_dout,
	input  wire                          fifo_empty,
	output ddr_xfer_pkg::ddr_data_t      wdata,
	output logic                         wvalid,
	output logic                         wlast,
	input  wire                          wready,
	output logic                         done
);
	import ddr_xfer_pkg::*;

	localparam int PTR_W  = $clog2(BUF_DEPTH);
	localparam int BEAT_W = $clog2(BURST_BEATS);
	localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(BURST_LEN);

	ddr_data_t         buf_mem [BUF_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [PTR_W:0]    fill;       // 0 .. BUF_DEPTH
	logic              push;
	logic              pop;
	logic              active;     // segment still owes fifo words
	logic [BEAT_W-1:0] rd_beat;
	burst_cnt_t        rd_burst;
	logic [BEAT_W-1:0] w_beat;
	burst_cnt_t        w_burst;
	logic              w_burst_last;

	// full when the top bit of fill is set
	assign fifo_rd_en = active && !fifo_empty && !fill[PTR_W];
	assign push       = fifo_rd_en;
	assign pop        = wvalid && wready;

	always_ff @(posedge ddr_user_clk) begin
		if (ddr_user_sync_rst) begin
			active   <= 1'b0;
			rd_beat  <= '0;
			rd_burst <= '0;
		end else if (seg.seg_start) begin
			active   <= (seg.num != '0);
			rd_beat  <= '0;
			rd_burst <= '0;
		end else if (push) begin
			rd_beat <= (rd_beat == LAST_BEAT) ? '0 : rd_beat + 1'b1;
			if (rd_beat == LAST_BEAT) begin
				if (rd_burst == seg.num - 32'd1) begin
					active   <= 1'b0;  // all words of the segment fetched
					rd_burst <= '0;
				end else begin
					rd_burst <= rd_burst + 32'd1;
				end
			end
		end
	end

	always_ff @(posedge ddr_user_clk) begin
		if (push)
			buf_mem[wr_ptr] <= fifo_dout;
	end

	always_ff @(posedge ddr_user_clk) begin
		if (ddr_user_sync_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	assign wvalid       = (fill != '0);
	assign wdata        = buf_mem[rd_ptr];
	assign wlast        = wvalid && (w_beat == LAST_BEAT);
	assign w_burst_last = (w_burst == seg.num - 32'd1);
	assign seg.seg_done = pop && wlast && w_burst_last;

	always_ff @(posedge ddr_user_clk) begin
		if (ddr_user_sync_rst) begin
			w_beat  <= '0;
			w_burst <= '0;
		end else if (pop) begin
			w_beat <= wlast ? '0 : w_beat + 1'b1;
			if (wlast)
				w_burst <= w_burst_last ? '0 : w_burst + 32'd1;
		end
	end

	always_ff @(posedge ddr_user_clk) begin
		if (ddr_user_sync_rst)
			done <= 1'b0;
		else
			done <= seg.seg_done && seg.last_seg;  // end of the whole list
	end

endmodule

`default_nettype wire

/* design/wr_segment_list.sv */
`timescale 1ns/1ps
`default_nettype none

module wr_segment_list (
	input  wire                        ddr_user_clk,
	input  wire                        ddr_user_sync_rst,
	input  wire                        cfg_valid,
	input  wire ddr_xfer_pkg::wr_cfg_t cfg_value,
	input  wire                        init_calib_complete,
	input  wire                        fifo_empty,
	seg_if.list                        seg
);
	import ddr_xfer_pkg::*;

	wr_cfg_t cfg_list;  // slots not yet handed out
	logic    armed;
	logic    start;
	logic    advance;

	// a new cfg_valid wins over a start in the same cycle
	assign start    = armed && !cfg_valid && !fifo_empty && init_calib_complete;
	assign advance  = start || (seg.seg_done && cfg_list != '0);
	assign seg.last_seg = (cfg_list == '0);

	always_ff @(posedge ddr_user_clk) begin
		if (ddr_user_sync_rst)
			armed <= 1'b0;
		else if (cfg_valid)
			armed <= 1'b1;
		else if (start)
			armed <= 1'b0;  // one run per load
	end

	always_ff @(posedge ddr_user_clk) begin
		if (ddr_user_sync_rst)
			cfg_list <= '0;
		else if (cfg_valid)
			cfg_list <= cfg_value;
		else if (advance)
			cfg_list <= {seg_t'('0), cfg_list[SEG_COUNT-1:1]};  // drop slot 0
	end

	always_ff @(posedge ddr_user_clk) begin
		if (advance) begin
			seg.head <= cfg_list[0].head[DDR_ADDR_W-1:0];
			seg.num  <= cfg_list[0].num;
		end
	end

	always_ff @(posedge ddr_user_clk) begin
		if (ddr_user_sync_rst)
			seg.seg_start <= 1'b0;
		else
			seg.seg_start <= advance;  // same edge as head/num load
	end

endmodule

`default_nettype wire

/* sim.f */
design/ddr_xfer_pkg.sv
design/seg_if.sv
design/wr_segment_list.sv
design/wr_addr_gen.sv
design/wr_data_path.sv
design/rd_channel.sv
design/ddr_xfer_top.sv
bench/ddr_xfer_sva.sv
bench/ddr_xfer_tb.sv
